//--- rtl/cpu_pkg.sv
package cpu_pkg;

	typedef logic [31:0] Word_t;
	typedef logic [31:0] Inst_t;
	typedef logic [31:0] InstAddr_t;
	typedef logic [4:0]  RegAddr_t;
	typedef logic [15:0] HalfWord_t;

	// one code per supported instruction, OP_INVALID must stay zero
	typedef enum logic [4:0] {
		OP_INVALID,
		OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLT, OP_SLTU,
		OP_SLL, OP_SRL, OP_SRA, OP_JR,
		OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_SLTI, OP_SLTIU,
		OP_LW, OP_SW, OP_BEQ, OP_BNE,
		OP_J, OP_JAL
	} Oper_t;

	// a register write still in flight in a later stage
	typedef struct packed {
		logic     we;
		RegAddr_t waddr;
		Word_t    wdata;
	} RegWriteReq_t;

	// primary opcodes, inst[31:26]
	localparam logic [5:0] OPC_SPECIAL = 6'h00;
	localparam logic [5:0] OPC_J       = 6'h02;
	localparam logic [5:0] OPC_JAL     = 6'h03;
	localparam logic [5:0] OPC_BEQ     = 6'h04;
	localparam logic [5:0] OPC_BNE     = 6'h05;
	localparam logic [5:0] OPC_ADDIU   = 6'h09;
	localparam logic [5:0] OPC_SLTI    = 6'h0a;
	localparam logic [5:0] OPC_SLTIU   = 6'h0b;
	localparam logic [5:0] OPC_ANDI    = 6'h0c;
	localparam logic [5:0] OPC_ORI     = 6'h0d;
	localparam logic [5:0] OPC_XORI    = 6'h0e;
	localparam logic [5:0] OPC_LUI     = 6'h0f;
	localparam logic [5:0] OPC_LW      = 6'h23;
	localparam logic [5:0] OPC_SW      = 6'h2b;

	// SPECIAL funct codes, inst[5:0]
	localparam logic [5:0] FN_SLL  = 6'h00;
	localparam logic [5:0] FN_SRL  = 6'h02;
	localparam logic [5:0] FN_SRA  = 6'h03;
	localparam logic [5:0] FN_JR   = 6'h08;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_NOR  = 6'h27;
	localparam logic [5:0] FN_SLT  = 6'h2a;
	localparam logic [5:0] FN_SLTU = 6'h2b;

	// $ra, target of JAL
	localparam logic [4:0] LINK_REG = 5'd31;

endpackage

//--- rtl/id_result_if.sv
`timescale 1ns/10ps

interface id_result_if;
	import cpu_pkg::*;

	Oper_t    op;
	// operands after forwarding
	Word_t    reg1;
	Word_t    reg2;
	Word_t    imm;
	logic     reg_we;
	RegAddr_t reg_waddr;

	modport dec (
		output op, reg1, reg2, imm, reg_we, reg_waddr
	);

	modport pipe (
		input op, reg1, reg2, imm, reg_we, reg_waddr
	);

endinterface

//--- rtl/id_type_i.sv
`timescale 1ns/10ps

module id_type_i (
	input  logic [5:0]     opcode_i,
	output cpu_pkg::Oper_t op_o,
	output logic           read_rt_o,
	output logic           write_rt_o,
	output logic           unsigned_imm_o
);
	import cpu_pkg::*;

	always_comb begin
		case (opcode_i)
			OPC_ADDIU: op_o = OP_ADDIU;
			OPC_SLTI:  op_o = OP_SLTI;
			OPC_SLTIU: op_o = OP_SLTIU;
			OPC_ANDI:  op_o = OP_ANDI;
			OPC_ORI:   op_o = OP_ORI;
			OPC_XORI:  op_o = OP_XORI;
			OPC_LUI:   op_o = OP_LUI;
			OPC_LW:    op_o = OP_LW;
			OPC_SW:    op_o = OP_SW;
			OPC_BEQ:   op_o = OP_BEQ;
			OPC_BNE:   op_o = OP_BNE;
			default:   op_o = OP_INVALID;
		endcase
	end

	// store data and branch compare both need rt as a source
	assign read_rt_o = (opcode_i == OPC_SW) || (opcode_i == OPC_BEQ) ||
		(opcode_i == OPC_BNE);

	// everything else in this group targets rt
	assign write_rt_o = (op_o != OP_INVALID) && !read_rt_o;

	// logical immediates are zero extended
	assign unsigned_imm_o = (opcode_i == OPC_ANDI) || (opcode_i == OPC_ORI) ||
		(opcode_i == OPC_XORI);

endmodule

//--- rtl/id_type_r.sv
`timescale 1ns/10ps

module id_type_r (
	input  cpu_pkg::Inst_t    inst_i,
	output cpu_pkg::Oper_t    op_o,
	output cpu_pkg::RegAddr_t reg_raddr1_o,
	output cpu_pkg::RegAddr_t reg_raddr2_o,
	output cpu_pkg::RegAddr_t reg_waddr_o,
	output logic              reg_we_o,
	output logic              use_shamt_o
);
	import cpu_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	RegAddr_t   rs, rt, rd;
	logic       valid;
	logic       is_shift;
	logic       is_jr;

	assign opcode = inst_i[31:26];
	assign rs     = inst_i[25:21];
	assign rt     = inst_i[20:16];
	assign rd     = inst_i[15:11];
	assign funct  = inst_i[5:0];

	always_comb begin
		op_o = OP_INVALID;
		if (opcode == OPC_SPECIAL) begin
			case (funct)
				FN_SLL:  op_o = OP_SLL;
				FN_SRL:  op_o = OP_SRL;
				FN_SRA:  op_o = OP_SRA;
				FN_JR:   op_o = OP_JR;
				FN_ADDU: op_o = OP_ADDU;
				FN_SUBU: op_o = OP_SUBU;
				FN_AND:  op_o = OP_AND;
				FN_OR:   op_o = OP_OR;
				FN_XOR:  op_o = OP_XOR;
				FN_NOR:  op_o = OP_NOR;
				FN_SLT:  op_o = OP_SLT;
				FN_SLTU: op_o = OP_SLTU;
				default: op_o = OP_INVALID;
			endcase
		end
	end

	assign valid    = (op_o != OP_INVALID);
	assign is_shift = (op_o == OP_SLL) || (op_o == OP_SRL) || (op_o == OP_SRA);
	assign is_jr    = (op_o == OP_JR);

	// shifts take their amount from shamt, so rs is unused
	assign reg_raddr1_o = (valid && !is_shift) ? rs : 5'd0;
	// jr only needs the target in rs
	assign reg_raddr2_o = (valid && !is_jr) ? rt : 5'd0;
	assign reg_we_o     = valid && !is_jr;
	assign reg_waddr_o  = reg_we_o ? rd : 5'd0;
	assign use_shamt_o  = is_shift;

endmodule

//--- rtl/regfile.sv
`timescale 1ns/10ps

module regfile (
	input  logic              clk,
	input  logic              rst_n_i,
	input  cpu_pkg::RegAddr_t raddr1_i,
	input  cpu_pkg::RegAddr_t raddr2_i,
	output cpu_pkg::Word_t    rdata1_o,
	output cpu_pkg::Word_t    rdata2_o,
	input  logic              we_i,
	input  cpu_pkg::RegAddr_t waddr_i,
	input  cpu_pkg::Word_t    wdata_i
);
	import cpu_pkg::*;

	Word_t regs [32];

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && waddr_i != 5'd0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// write-first read, $0 is hardwired
	function automatic Word_t read_port(RegAddr_t addr);
		Word_t data;
		if (addr == 5'd0) begin
			data = '0;
		end else if (we_i && waddr_i == addr) begin
			data = wdata_i;
		end else begin
			data = regs[addr];
		end
		return data;
	endfunction

	always_comb begin
		rdata1_o = read_port(raddr1_i);
		rdata2_o = read_port(raddr2_i);
	end

endmodule

//--- rtl/cpu_id.sv
`timescale 1ns/10ps

module cpu_id (
	input  cpu_pkg::Inst_t        inst_i,
	input  cpu_pkg::InstAddr_t    pc_i,
	input  cpu_pkg::Word_t        rdata1_i,
	input  cpu_pkg::Word_t        rdata2_i,
	input  cpu_pkg::RegWriteReq_t ex_wr_i,
	input  cpu_pkg::RegWriteReq_t mem_wr_i,
	input  logic                  ex_load_i,
	output cpu_pkg::RegAddr_t     raddr1_o,
	output cpu_pkg::RegAddr_t     raddr2_o,
	output logic                  stall_req_o,
	id_result_if.dec              res
);
	import cpu_pkg::*;

	logic [5:0]  opcode;
	RegAddr_t    rs, rt;
	logic [4:0]  shamt;
	HalfWord_t   immediate;
	logic [25:0] instr_index;
	InstAddr_t   pc_plus4, pc_plus8;
	Word_t       imm_zero_ext, imm_sign_ext, jump_target;

	Oper_t       op_type_i;
	logic        read_rt_i, write_rt_i, unsigned_imm_i;
	Oper_t       op_type_r;
	RegAddr_t    raddr1_r, raddr2_r, waddr_r;
	logic        we_r, use_shamt_r;

	Oper_t       op;
	Word_t       imm;
	logic        reg_we;
	RegAddr_t    reg_waddr;
	logic        is_link;

	// field split
	assign opcode      = inst_i[31:26];
	assign rs          = inst_i[25:21];
	assign rt          = inst_i[20:16];
	assign shamt       = inst_i[10:6];
	assign immediate   = inst_i[15:0];
	assign instr_index = inst_i[25:0];

	assign pc_plus4     = pc_i + 32'd4;
	assign pc_plus8     = pc_i + 32'd8;
	assign imm_zero_ext = {16'h0, immediate};
	assign imm_sign_ext = {{16{immediate[15]}}, immediate};
	// target stays inside the 256 MB region of the delay slot
	assign jump_target  = {pc_plus4[31:28], instr_index, 2'b00};

	id_type_i u_type_i (
		.opcode_i       (opcode),
		.op_o           (op_type_i),
		.read_rt_o      (read_rt_i),
		.write_rt_o     (write_rt_i),
		.unsigned_imm_o (unsigned_imm_i)
	);

	id_type_r u_type_r (
		.inst_i       (inst_i),
		.op_o         (op_type_r),
		.reg_raddr1_o (raddr1_r),
		.reg_raddr2_o (raddr2_r),
		.reg_waddr_o  (waddr_r),
		.reg_we_o     (we_r),
		.use_shamt_o  (use_shamt_r)
	);

	// format select, I first, then J, then R
	always_comb begin
		op        = OP_INVALID;
		raddr1_o  = 5'd0;
		raddr2_o  = 5'd0;
		imm       = '0;
		reg_we    = 1'b0;
		reg_waddr = 5'd0;
		is_link   = 1'b0;
		if (op_type_i != OP_INVALID) begin
			op        = op_type_i;
			raddr1_o  = rs;
			raddr2_o  = read_rt_i ? rt : 5'd0;
			imm       = unsigned_imm_i ? imm_zero_ext : imm_sign_ext;
			reg_we    = write_rt_i;
			reg_waddr = rt;
		end else if (opcode == OPC_J || opcode == OPC_JAL) begin
			op        = (opcode == OPC_JAL) ? OP_JAL : OP_J;
			imm       = jump_target;
			// only jal links, into $31
			reg_we    = (opcode == OPC_JAL);
			reg_waddr = LINK_REG;
			is_link   = (opcode == OPC_JAL);
		end else if (op_type_r != OP_INVALID) begin
			op        = op_type_r;
			raddr1_o  = raddr1_r;
			raddr2_o  = raddr2_r;
			imm       = use_shamt_r ? {27'd0, shamt} : '0;
			reg_we    = we_r;
			reg_waddr = waddr_r;
		end
	end

	// EX result is newer than MEM, so it wins
	function automatic Word_t fwd_operand(RegAddr_t addr, Word_t rf_data);
		Word_t data;
		if (addr == 5'd0) begin
			data = '0;
		end else if (ex_wr_i.we && ex_wr_i.waddr == addr) begin
			data = ex_wr_i.wdata;
		end else if (mem_wr_i.we && mem_wr_i.waddr == addr) begin
			data = mem_wr_i.wdata;
		end else begin
			data = rf_data;
		end
		return data;
	endfunction

	// load data is not ready until MEM, hold the instruction one more cycle
	assign stall_req_o = ex_load_i &&
		((raddr1_o != 5'd0 && ex_wr_i.waddr == raddr1_o) ||
		 (raddr2_o != 5'd0 && ex_wr_i.waddr == raddr2_o));

	assign res.op        = op;
	assign res.imm       = imm;
	assign res.reg_we    = reg_we;
	assign res.reg_waddr = reg_waddr;

	always_comb begin
		res.reg1 = is_link ? pc_plus8 : fwd_operand(raddr1_o, rdata1_i);
		res.reg2 = fwd_operand(raddr2_o, rdata2_i);
	end

endmodule

//--- rtl/id_issue.sv
`timescale 1ns/10ps

module id_issue (
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              inst_req_i,
	output logic              inst_ack_o,
	input  logic              stall_req_i,
	id_result_if.pipe         res,
	output logic              ex_valid_o,
	output cpu_pkg::Oper_t    ex_op_o,
	output cpu_pkg::Word_t    ex_reg1_o,
	output cpu_pkg::Word_t    ex_reg2_o,
	output cpu_pkg::Word_t    ex_imm_o,
	output logic              ex_reg_we_o,
	output cpu_pkg::RegAddr_t ex_reg_waddr_o
);
	import cpu_pkg::*;

	logic capture;

	// new request, not yet acked, and no load-use hazard
	assign capture = inst_req_i && !inst_ack_o && !stall_req_i;

	// four-phase handshake with fetch
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			inst_ack_o <= 1'b0;
			ex_valid_o <= 1'b0;
		end else begin
			// a stalled cycle leaves a bubble in EX
			ex_valid_o <= capture;
			if (capture) begin
				inst_ack_o <= 1'b1;
			end else if (!inst_req_i) begin
				inst_ack_o <= 1'b0;
			end
		end
	end

	// ID/EX pipeline register
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			ex_op_o        <= OP_INVALID;
			ex_reg1_o      <= '0;
			ex_reg2_o      <= '0;
			ex_imm_o       <= '0;
			ex_reg_we_o    <= 1'b0;
			ex_reg_waddr_o <= 5'd0;
		end else if (capture) begin
			ex_op_o        <= res.op;
			ex_reg1_o      <= res.reg1;
			ex_reg2_o      <= res.reg2;
			ex_imm_o       <= res.imm;
			ex_reg_we_o    <= res.reg_we;
			ex_reg_waddr_o <= res.reg_waddr;
		end
	end

endmodule

//--- rtl/id_stage_top.sv
`timescale 1ns/10ps

module id_stage_top (
	input  logic               clk,
	input  logic               rst_n_i,
	input  logic               inst_req_i,
	output logic               inst_ack_o,
	input  cpu_pkg::Inst_t     inst_i,
	input  cpu_pkg::InstAddr_t pc_i,
	input  logic               ex_wr_we_i,
	input  cpu_pkg::RegAddr_t  ex_wr_waddr_i,
	input  cpu_pkg::Word_t     ex_wr_wdata_i,
	input  logic               ex_mem_ce_i,
	input  logic               ex_mem_we_i,
	input  logic               mem_wr_we_i,
	input  cpu_pkg::RegAddr_t  mem_wr_waddr_i,
	input  cpu_pkg::Word_t     mem_wr_wdata_i,
	input  logic               wb_we_i,
	input  cpu_pkg::RegAddr_t  wb_waddr_i,
	input  cpu_pkg::Word_t     wb_wdata_i,
	output logic               ex_valid_o,
	output cpu_pkg::Oper_t     ex_op_o,
	output cpu_pkg::Word_t     ex_reg1_o,
	output cpu_pkg::Word_t     ex_reg2_o,
	output cpu_pkg::Word_t     ex_imm_o,
	output logic               ex_reg_we_o,
	output cpu_pkg::RegAddr_t  ex_reg_waddr_o
);
	import cpu_pkg::*;

	RegWriteReq_t ex_wr, mem_wr;
	RegAddr_t     raddr1, raddr2;
	Word_t        rdata1, rdata2;
	logic         ex_load;
	logic         stall_req;

	id_result_if  id_res ();

	assign ex_wr   = '{we: ex_wr_we_i, waddr: ex_wr_waddr_i, wdata: ex_wr_wdata_i};
	assign mem_wr  = '{we: mem_wr_we_i, waddr: mem_wr_waddr_i, wdata: mem_wr_wdata_i};
	// memory read enabled without write means a load sits in EX
	assign ex_load = ex_mem_ce_i && !ex_mem_we_i;

	regfile u_regfile (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.raddr1_i (raddr1),
		.raddr2_i (raddr2),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2),
		.we_i     (wb_we_i),
		.waddr_i  (wb_waddr_i),
		.wdata_i  (wb_wdata_i)
	);

	cpu_id u_cpu_id (
		.inst_i      (inst_i),
		.pc_i        (pc_i),
		.rdata1_i    (rdata1),
		.rdata2_i    (rdata2),
		.ex_wr_i     (ex_wr),
		.mem_wr_i    (mem_wr),
		.ex_load_i   (ex_load),
		.raddr1_o    (raddr1),
		.raddr2_o    (raddr2),
		.stall_req_o (stall_req),
		.res         (id_res.dec)
	);

	id_issue u_id_issue (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.inst_req_i     (inst_req_i),
		.inst_ack_o     (inst_ack_o),
		.stall_req_i    (stall_req),
		.res            (id_res.pipe),
		.ex_valid_o     (ex_valid_o),
		.ex_op_o        (ex_op_o),
		.ex_reg1_o      (ex_reg1_o),
		.ex_reg2_o      (ex_reg2_o),
		.ex_imm_o       (ex_imm_o),
		.ex_reg_we_o    (ex_reg_we_o),
		.ex_reg_waddr_o (ex_reg_waddr_o)
	);

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
	output logic clk_o,
	output logic rst_n_o
);
	localparam int HALF_PERIOD  = 5;
	localparam int RESET_CYCLES = 3;

	initial begin
		clk_o = 1'b0;
		forever #HALF_PERIOD clk_o = ~clk_o;
	end

	// reset is sampled by the DUT on these edges
	initial begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		#1 rst_n_o = 1'b1;
	end

endmodule

//--- sim/tb_id_stage.sv
`timescale 1ns/10ps

module tb_id_stage;
	import cpu_pkg::*;

	typedef enum bit {ROW_WB, ROW_ISSUE} row_kind_t;

	typedef struct packed {
		row_kind_t    kind;
		Inst_t        inst;
		InstAddr_t    pc;
		RegWriteReq_t ex;
		RegWriteReq_t mem;
		logic         load;
		logic         ex_store;
		RegWriteReq_t wb;
		Oper_t        exp_op;
		logic         exp_stall;
	} row_t;

	localparam RegWriteReq_t NO_WR = '0;

	logic clk, rst_n;
	logic inst_req, inst_ack;
	Inst_t inst;
	InstAddr_t pc;
	logic ex_wr_we, ex_mem_ce, ex_mem_we, mem_wr_we, wb_we;
	RegAddr_t ex_wr_waddr, mem_wr_waddr, wb_waddr;
	Word_t ex_wr_wdata, mem_wr_wdata, wb_wdata;
	logic ex_valid, ex_reg_we;
	Oper_t ex_op;
	Word_t ex_reg1, ex_reg2, ex_imm;
	RegAddr_t ex_reg_waddr;

	row_t rows[$];
	// register contents as the testbench expects them
	Word_t ref_regs [32];
	logic [31:0] lfsr_state = 32'h553c;
	int cycle_count = 0;
	int cycle_limit = 100000;

	tb_clock clock_gen (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	id_stage_top dut (
		.clk (clk), .rst_n_i (rst_n),
		.inst_req_i (inst_req), .inst_ack_o (inst_ack), .inst_i (inst), .pc_i (pc),
		.ex_wr_we_i (ex_wr_we), .ex_wr_waddr_i (ex_wr_waddr), .ex_wr_wdata_i (ex_wr_wdata),
		.ex_mem_ce_i (ex_mem_ce), .ex_mem_we_i (ex_mem_we),
		.mem_wr_we_i (mem_wr_we), .mem_wr_waddr_i (mem_wr_waddr),
		.mem_wr_wdata_i (mem_wr_wdata),
		.wb_we_i (wb_we), .wb_waddr_i (wb_waddr), .wb_wdata_i (wb_wdata),
		.ex_valid_o (ex_valid), .ex_op_o (ex_op), .ex_reg1_o (ex_reg1),
		.ex_reg2_o (ex_reg2), .ex_imm_o (ex_imm), .ex_reg_we_o (ex_reg_we),
		.ex_reg_waddr_o (ex_reg_waddr)
	);

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("run stopped after %0d cycles, the handshake hung", cycle_count);
			$display("sim failed");
			$fatal(1, "cycle limit reached");
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			$display("sim failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// galois form, taps 32 22 2 1
	function automatic logic next_random_bit();
		lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
		return lfsr_state[0];
	endfunction

	function automatic Word_t random_word();
		Word_t w;
		w = '0;
		for (int b = 0; b < 32; b++) begin
			w = {w[30:0], next_random_bit()};
		end
		return w;
	endfunction

	function automatic Inst_t enc_i(input logic [5:0] opc, input RegAddr_t rs, input RegAddr_t rt,
		input HalfWord_t imm);
		return {opc, rs, rt, imm};
	endfunction

	function automatic Inst_t enc_r(input RegAddr_t rs, input RegAddr_t rt, input RegAddr_t rd,
		input logic [4:0] shamt, input logic [5:0] fn);
		return {OPC_SPECIAL, rs, rt, rd, shamt, fn};
	endfunction

	function automatic Inst_t enc_j(input logic [5:0] opc, input logic [25:0] index);
		return {opc, index};
	endfunction

	function automatic RegWriteReq_t wreq(input logic we, input RegAddr_t addr, input Word_t data);
		RegWriteReq_t w;
		w.we = we;
		w.waddr = addr;
		w.wdata = data;
		return w;
	endfunction

	// $0, then EX, then MEM, then the register file
	function automatic Word_t operand(input RegAddr_t addr, input RegWriteReq_t ex,
		input RegWriteReq_t mem);
		if (addr == 5'd0) begin
			return '0;
		end else if (ex.we && ex.waddr == addr) begin
			return ex.wdata;
		end else if (mem.we && mem.waddr == addr) begin
			return mem.wdata;
		end
		return ref_regs[addr];
	endfunction

	function automatic void predict_result(input row_t r, output Word_t reg1, output Word_t reg2,
		output Word_t imm, output logic we, output RegAddr_t waddr);
		RegAddr_t a1, a2;
		InstAddr_t pc4;
		Word_t sext;
		logic link;
		a1 = 5'd0;
		a2 = 5'd0;
		imm = '0;
		we = 1'b0;
		waddr = 5'd0;
		link = 1'b0;
		pc4 = r.pc + 32'd4;
		sext = {{16{r.inst[15]}}, r.inst[15:0]};
		case (r.inst[31:26])
			OPC_ADDIU, OPC_SLTI, OPC_SLTIU, OPC_LW, OPC_LUI, OPC_ANDI, OPC_ORI, OPC_XORI: begin
				a1 = r.inst[25:21];
				imm = (r.inst[31:26] inside {OPC_ANDI, OPC_ORI, OPC_XORI}) ?
					{16'h0, r.inst[15:0]} : sext;
				we = 1'b1;
				waddr = r.inst[20:16];
			end
			OPC_SW, OPC_BEQ, OPC_BNE: begin
				a1 = r.inst[25:21];
				a2 = r.inst[20:16];
				imm = sext;
			end
			OPC_J, OPC_JAL: begin
				imm = {pc4[31:28], r.inst[25:0], 2'b00};
				link = (r.inst[31:26] == OPC_JAL);
				we = link;
				waddr = 5'd31;
			end
			OPC_SPECIAL: begin
				case (r.inst[5:0])
					FN_SLL, FN_SRL, FN_SRA: begin
						a2 = r.inst[20:16];
						imm = {27'd0, r.inst[10:6]};
						we = 1'b1;
						waddr = r.inst[15:11];
					end
					FN_JR: a1 = r.inst[25:21];
					FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU: begin
						a1 = r.inst[25:21];
						a2 = r.inst[20:16];
						we = 1'b1;
						waddr = r.inst[15:11];
					end
					default: ;
				endcase
			end
			default: ;
		endcase
		reg1 = link ? (r.pc + 32'd8) : operand(a1, r.ex, r.mem);
		reg2 = operand(a2, r.ex, r.mem);
	endfunction

	task automatic add_issue(input Inst_t i, input InstAddr_t p, input RegWriteReq_t ex,
		input RegWriteReq_t mem, input logic load, input RegWriteReq_t wb, input Oper_t op,
		input logic stall);
		row_t r;
		r = '0;
		r.kind = ROW_ISSUE;
		r.inst = i;
		r.pc = p;
		r.ex = ex;
		r.mem = mem;
		r.load = load;
		r.wb = wb;
		r.exp_op = op;
		r.exp_stall = stall;
		rows.push_back(r);
	endtask

	task automatic add_dec(input Inst_t i, input InstAddr_t p, input Oper_t op);
		add_issue(i, p, NO_WR, NO_WR, 1'b0, NO_WR, op, 1'b0);
	endtask

	task automatic add_wb(input RegAddr_t addr, input Word_t data);
		add_issue('0, '0, NO_WR, NO_WR, 1'b0, wreq(1'b1, addr, data), OP_INVALID, 1'b0);
		rows[rows.size() - 1].kind = ROW_WB;
	endtask

	task automatic write_reg(input RegAddr_t addr, input Word_t data);
		@(posedge clk);
		#1;
		wb_we = 1'b1;
		wb_waddr = addr;
		wb_wdata = data;
		if (addr != 5'd0) begin
			ref_regs[addr] = data;
		end
		@(posedge clk);
		#1;
		wb_we = 1'b0;
	endtask

	task automatic run_issue(input row_t r);
		Word_t exp_reg1, exp_reg2, exp_imm;
		logic exp_we;
		RegAddr_t exp_waddr;
		int waited;
		@(posedge clk);
		#1;
		inst = r.inst;
		pc = r.pc;
		{ex_wr_we, ex_wr_waddr, ex_wr_wdata} = r.ex;
		{mem_wr_we, mem_wr_waddr, mem_wr_wdata} = r.mem;
		{wb_we, wb_waddr, wb_wdata} = r.wb;
		ex_mem_ce = r.load;
		ex_mem_we = r.ex_store;
		if (r.wb.we && r.wb.waddr != 5'd0) begin
			ref_regs[r.wb.waddr] = r.wb.wdata;
		end
		inst_req = 1'b1;
		if (r.exp_stall) begin
			repeat (4) begin
				@(negedge clk);
				check_value("inst_ack_o in stall", 32'(inst_ack), 32'd0);
				check_value("ex_valid_o in stall", 32'(ex_valid), 32'd0);
			end
			// the load moves on to MEM
			@(posedge clk);
			#1;
			ex_mem_ce = 1'b0;
		end
		predict_result(r, exp_reg1, exp_reg2, exp_imm, exp_we, exp_waddr);
		// the request is first seen at the next rising edge
		@(negedge clk);
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!inst_ack);
		check_value("capture latency", waited, 32'd1);
		check_value("ex_valid_o", 32'(ex_valid), 32'd1);
		check_value("ex_op_o", 32'(ex_op), 32'(r.exp_op));
		check_value("ex_reg1_o", ex_reg1, exp_reg1);
		check_value("ex_reg2_o", ex_reg2, exp_reg2);
		check_value("ex_imm_o", ex_imm, exp_imm);
		check_value("ex_reg_we_o", 32'(ex_reg_we), 32'(exp_we));
		if (exp_we) begin
			check_value("ex_reg_waddr_o", 32'(ex_reg_waddr), 32'(exp_waddr));
		end
		@(posedge clk);
		#1;
		inst_req = 1'b0;
		wb_we = 1'b0;
		ex_mem_ce = 1'b0;
		ex_mem_we = 1'b0;
		@(negedge clk);
		check_value("ex_valid_o after capture", 32'(ex_valid), 32'd0);
		while (inst_ack) begin
			@(negedge clk);
		end
	endtask

	initial begin
		{inst_req, inst, pc, ex_mem_ce, ex_mem_we} = '0;
		{ex_wr_we, ex_wr_waddr, ex_wr_wdata, mem_wr_we, mem_wr_waddr, mem_wr_wdata} = '0;
		{wb_we, wb_waddr, wb_wdata} = '0;
		foreach (ref_regs[i]) begin
			ref_regs[i] = '0;
		end

		add_wb(5'd8, 32'h0000_1234);
		add_wb(5'd9, 32'hffff_0001);
		add_dec(enc_i(OPC_ADDIU, 5'd8, 5'd10, 16'hfffc), 32'h0040_0000, OP_ADDIU);
		add_dec(enc_i(OPC_SLTI, 5'd9, 5'd11, 16'h8000), 32'h0040_0004, OP_SLTI);
		add_dec(enc_i(OPC_SLTIU, 5'd9, 5'd11, 16'h7fff), 32'h0040_0008, OP_SLTIU);
		add_dec(enc_i(OPC_LW, 5'd8, 5'd12, 16'hff00), 32'h0040_000c, OP_LW);
		add_dec(enc_i(OPC_ANDI, 5'd8, 5'd13, 16'h8001), 32'h0040_0010, OP_ANDI);
		add_dec(enc_i(OPC_ORI, 5'd9, 5'd13, 16'hf0f0), 32'h0040_0014, OP_ORI);
		add_dec(enc_i(OPC_XORI, 5'd9, 5'd13, 16'h8888), 32'h0040_0018, OP_XORI);
		add_dec(enc_i(OPC_LUI, 5'd0, 5'd14, 16'habcd), 32'h0040_001c, OP_LUI);
		add_dec(enc_i(OPC_SW, 5'd8, 5'd9, 16'h0010), 32'h0040_0020, OP_SW);
		add_dec(enc_i(OPC_BEQ, 5'd8, 5'd9, 16'hfff8), 32'h0040_0024, OP_BEQ);
		add_dec(enc_r(5'd8, 5'd9, 5'd14, 5'd0, FN_SUBU), 32'h0040_0028, OP_SUBU);
		add_dec(enc_r(5'd3, 5'd4, 5'd15, 5'd0, FN_NOR), 32'h0040_002c, OP_NOR);
		add_dec(enc_r(5'd5, 5'd6, 5'd15, 5'd0, FN_SLTU), 32'h0040_0030, OP_SLTU);
		add_dec(enc_r(5'd0, 5'd9, 5'd15, 5'd7, FN_SLL), 32'h0040_0034, OP_SLL);
		add_dec(enc_r(5'd0, 5'd9, 5'd15, 5'd31, FN_SRA), 32'h0040_0038, OP_SRA);
		add_dec(enc_r(5'd31, 5'd0, 5'd0, 5'd0, FN_JR), 32'h0040_003c, OP_JR);
		add_dec(enc_r(5'd8, 5'd9, 5'd10, 5'd0, 6'h3f), 32'h0040_0040, OP_INVALID);
		add_dec(enc_i(6'h3f, 5'd8, 5'd9, 16'h1234), 32'h0040_0044, OP_INVALID);
		add_dec(enc_j(OPC_J, 26'h012_3456), 32'hf000_0ffc, OP_J);
		add_dec(enc_j(OPC_JAL, 26'h3ff_fffe), 32'h3fff_fffc, OP_JAL);
		// forwarding priority and $0
		add_issue(enc_r(5'd8, 5'd9, 5'd16, 5'd0, FN_ADDU), 32'h0040_0100,
			wreq(1'b1, 5'd8, 32'haaaa_0001), wreq(1'b1, 5'd9, 32'hcccc_0002), 1'b0, NO_WR,
			OP_ADDU, 1'b0);
		add_issue(enc_r(5'd9, 5'd8, 5'd16, 5'd0, FN_AND), 32'h0040_0104,
			wreq(1'b1, 5'd9, 32'hbbbb_0003), wreq(1'b1, 5'd9, 32'hdddd_0004), 1'b0, NO_WR,
			OP_AND, 1'b0);
		add_issue(enc_r(5'd0, 5'd0, 5'd16, 5'd0, FN_OR), 32'h0040_0108,
			wreq(1'b1, 5'd0, 32'hdead_0000), wreq(1'b1, 5'd0, 32'hbeef_0000), 1'b0, NO_WR,
			OP_OR, 1'b0);
		add_issue(enc_r(5'd8, 5'd9, 5'd16, 5'd0, FN_SLT), 32'h0040_010c,
			wreq(1'b0, 5'd8, 32'h0bad_0005), NO_WR, 1'b0, NO_WR, OP_SLT, 1'b0);
		add_issue(enc_r(5'd20, 5'd21, 5'd22, 5'd0, FN_XOR), 32'h0040_0110, NO_WR, NO_WR,
			1'b0, wreq(1'b1, 5'd20, 32'h600d_f00d), OP_XOR, 1'b0);
		// load-use hazard
		add_issue(enc_r(5'd8, 5'd9, 5'd17, 5'd0, FN_ADDU), 32'h0040_0200,
			wreq(1'b1, 5'd8, 32'h1111_2222), NO_WR, 1'b1, NO_WR, OP_ADDU, 1'b1);
		add_issue(enc_i(OPC_SW, 5'd8, 5'd9, 16'h0004), 32'h0040_0204,
			wreq(1'b1, 5'd9, 32'h3333_4444), NO_WR, 1'b1, NO_WR, OP_SW, 1'b1);
		add_issue(enc_r(5'd8, 5'd9, 5'd17, 5'd0, FN_ADDU), 32'h0040_0208,
			wreq(1'b1, 5'd25, 32'h5555_6666), NO_WR, 1'b1, NO_WR, OP_ADDU, 1'b0);
		add_issue(enc_r(5'd0, 5'd9, 5'd18, 5'd0, FN_ADDU), 32'h0040_020c,
			wreq(1'b1, 5'd0, 32'h7777_8888), NO_WR, 1'b1, NO_WR, OP_ADDU, 1'b0);
		add_issue(enc_r(5'd8, 5'd9, 5'd19, 5'd3, FN_SRL), 32'h0040_0210,
			wreq(1'b1, 5'd8, 32'h9999_aaaa), NO_WR, 1'b1, NO_WR, OP_SRL, 1'b0);
		// a store in EX is not a load and holds nothing back
		add_issue(enc_r(5'd8, 5'd9, 5'd17, 5'd0, FN_ADDU), 32'h0040_0214,
			wreq(1'b1, 5'd8, 32'hcafe_0007), NO_WR, 1'b1, NO_WR, OP_ADDU, 1'b0);
		rows[rows.size() - 1].ex_store = 1'b1;
		cycle_limit = rows.size() * 40 + 3 + 2 * 32;

		@(posedge rst_n);
		@(negedge clk);
		check_value("inst_ack_o after reset", 32'(inst_ack), 32'd0);
		check_value("ex_valid_o after reset", 32'(ex_valid), 32'd0);
		check_value("ex_op_o after reset", 32'(ex_op), 32'(OP_INVALID));

		// fill every register so no operand reads a reset value
		for (int a = 1; a < 32; a++) begin
			write_reg(5'(a), random_word());
		end
		foreach (rows[i]) begin
			if (rows[i].kind == ROW_WB) begin
				write_reg(rows[i].wb.waddr, rows[i].wb.wdata);
			end else begin
				run_issue(rows[i]);
			end
		end
		$display("sim passed");
		$finish;
	end

endmodule

//--- verilog.f
rtl/cpu_pkg.sv
rtl/id_result_if.sv
rtl/id_type_i.sv
rtl/id_type_r.sv
rtl/regfile.sv
rtl/cpu_id.sv
rtl/id_issue.sv
rtl/id_stage_top.sv
sim/tb_clock.sv
sim/tb_id_stage.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       = tb_id_stage
FILELIST  = verilog.f
BUILD_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the simulation with $(VERILATOR)"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
